//--- hw/lsu_pkg.sv
package lsu_pkg;

  ////////////////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////////////////

  localparam int DATA_W = 32;
  localparam int BE_W = 4;
  localparam int BYTE_W = DATA_W / BE_W;

  // word address into the data cache.
  localparam int ADDR_W = 6;
  localparam int DC_WORDS = 1 << ADDR_W;

  // destination register tag carried by a load.
  localparam int TAG_W = 5;

  ////////////////////////////////////////////////////
  // dispatch operation word
  ////////////////////////////////////////////////////

  // the same 42-bit word is read as a store or as a load.
  // both views keep the word address in the low bits.
  typedef union packed {
    struct packed {
      logic [DATA_W-1:0] data;
      logic [BE_W-1:0]   be;
      logic [ADDR_W-1:0] addr;
    } st;
    struct packed {
      logic [DATA_W+BE_W-TAG_W-1:0] pad;
      logic [TAG_W-1:0]             tag;
      logic [ADDR_W-1:0]            addr;
    } ld;
  } mem_op_u;

endpackage

//--- hw/lsu_dcache.sv
`timescale 1ns/100ps

module lsu_dcache
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset,

  input  logic [ADDR_W-1:0] i_rd_addr,

  input  logic              i_wr_en,
  input  logic [ADDR_W-1:0] i_wr_addr,
  input  logic [DATA_W-1:0] i_wr_data,
  input  logic [BE_W-1:0]   i_wr_be,

  output logic [DATA_W-1:0] o_rd_data,
  output logic              o_rd_written
);

  logic [DATA_W-1:0]   mem [DC_WORDS];
  logic [DC_WORDS-1:0] written;

  // byte lanes are written independently under the byte enables.
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < BE_W; b++) begin
        if (i_wr_be[b]) begin
          mem[i_wr_addr][b*BYTE_W +: BYTE_W] <= i_wr_data[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // a word counts as written once any of its bytes has been stored.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      written <= '0;
    end else if (i_wr_en) begin
      written[i_wr_addr] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_rd_written <= 1'b0;
    end else begin
      o_rd_written <= written[i_rd_addr];
    end
  end

  // the read returns the old word when the same address is written on this edge.
  always_ff @(posedge i_clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

//--- hw/lsu_load_pipe.sv
`timescale 1ns/100ps

module lsu_load_pipe
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset,

  input  logic              i_ld_valid,
  input  mem_op_u           i_ld_op,

  // stage one address to the cache.
  output logic [ADDR_W-1:0] o_rd_addr,

  // stage one look-up into the store queue.
  output logic              o_search_valid,
  output logic [ADDR_W-1:0] o_search_addr,

  // stage two towards the merge.
  output logic              o_e2_valid,
  output logic [TAG_W-1:0]  o_e2_tag
);

  logic              e1_valid;
  logic [TAG_W-1:0]  e1_tag;
  logic [ADDR_W-1:0] e1_addr;

  ////////////////////////////////////////////////////
  // stage one
  ////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      e1_valid <= 1'b0;
    end else begin
      e1_valid <= i_ld_valid;
    end
  end

  // only the load view of the dispatch word matters here.
  always_ff @(posedge i_clk) begin
    if (i_ld_valid) begin
      e1_tag  <= i_ld_op.ld.tag;
      e1_addr <= i_ld_op.ld.addr;
    end
  end

  // cache and store queue both sample this address at the next edge.
  assign o_rd_addr      = e1_addr;
  assign o_search_valid = e1_valid;
  assign o_search_addr  = e1_addr;

  ////////////////////////////////////////////////////
  // stage two
  ////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_e2_valid <= 1'b0;
    end else begin
      o_e2_valid <= e1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_e2_tag <= e1_tag;
  end

endmodule

//--- hw/lsu_stq.sv
`timescale 1ns/100ps

module lsu_stq
  import lsu_pkg::*;
#(
  parameter int STQ_DEPTH = 4
) (
  input  logic              i_clk,
  input  logic              i_reset,

  // store dispatch.
  input  logic              i_st_valid,
  input  mem_op_u           i_st_op,
  output logic              o_ready,

  // commit retires the head entry into the cache.
  input  logic              i_commit,
  output logic              o_wr_en,
  output logic [ADDR_W-1:0] o_wr_addr,
  output logic [DATA_W-1:0] o_wr_data,
  output logic [BE_W-1:0]   o_wr_be,

  // load look-up.
  input  logic              i_search_valid,
  input  logic [ADDR_W-1:0] i_search_addr,
  output logic [DATA_W-1:0] o_fwd_data,
  output logic [BE_W-1:0]   o_fwd_be
);

  localparam int PTR_W = $clog2(STQ_DEPTH);

  logic [ADDR_W-1:0] entry_addr [STQ_DEPTH];
  logic [DATA_W-1:0] entry_data [STQ_DEPTH];
  logic [BE_W-1:0]   entry_be   [STQ_DEPTH];

  logic [PTR_W-1:0]  head_ptr;
  logic [PTR_W-1:0]  tail_ptr;
  logic [PTR_W:0]    count;

  logic              push;
  logic              pop;
  logic [DATA_W-1:0] match_data;
  logic [BE_W-1:0]   match_be;

  assign o_ready = count < (PTR_W+1)'(STQ_DEPTH);
  assign push    = i_st_valid & o_ready;
  assign pop     = i_commit & (count != '0);

  ////////////////////////////////////////////////////
  // queue control
  ////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (push) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
      if (pop) begin
        head_ptr <= head_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // entries are filled from the store view of the dispatch word.
  always_ff @(posedge i_clk) begin
    if (push) begin
      entry_addr[tail_ptr] <= i_st_op.st.addr;
      entry_data[tail_ptr] <= i_st_op.st.data;
      entry_be[tail_ptr]   <= i_st_op.st.be;
    end
  end

  assign o_wr_en   = pop;
  assign o_wr_addr = entry_addr[head_ptr];
  assign o_wr_data = entry_data[head_ptr];
  assign o_wr_be   = entry_be[head_ptr];

  ////////////////////////////////////////////////////
  // forwarding search
  ////////////////////////////////////////////////////

  // entries are scanned oldest first, so a younger match overwrites an older one.
  always_comb begin
    logic [PTR_W-1:0] idx;
    match_data = '0;
    match_be   = '0;
    for (int i = 0; i < STQ_DEPTH; i++) begin
      idx = head_ptr + PTR_W'(i);
      if (((PTR_W+1)'(i) < count) && (entry_addr[idx] == i_search_addr)) begin
        for (int b = 0; b < BE_W; b++) begin
          if (entry_be[idx][b]) begin
            match_be[b] = 1'b1;
            match_data[b*BYTE_W +: BYTE_W] = entry_data[idx][b*BYTE_W +: BYTE_W];
          end
        end
      end
    end
  end

  // a head retiring on this edge is still part of the search.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_fwd_be <= '0;
    end else begin
      o_fwd_be <= i_search_valid ? match_be : '0;
    end
  end

  always_ff @(posedge i_clk) begin
    o_fwd_data <= match_data;
  end

endmodule

//--- hw/lsu_fwd_merge.sv
`timescale 1ns/100ps

module lsu_fwd_merge
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset,

  input  logic              i_e2_valid,
  input  logic [TAG_W-1:0]  i_e2_tag,
  input  logic [DATA_W-1:0] i_rd_data,
  input  logic              i_rd_written,
  input  logic [DATA_W-1:0] i_fwd_data,
  input  logic [BE_W-1:0]   i_fwd_be,

  output logic              o_ld_valid,
  output logic [TAG_W-1:0]  o_ld_tag,
  output logic [DATA_W-1:0] o_ld_data,
  output logic              o_ld_forwarded
);

  logic [DATA_W-1:0] cache_word;
  logic [DATA_W-1:0] merged;

  logic              e3_valid;
  logic [TAG_W-1:0]  e3_tag;
  logic [DATA_W-1:0] e3_data;
  logic              e3_forwarded;

  // a word that was never written reads as zero.
  assign cache_word = i_rd_written ? i_rd_data : '0;

  always_comb begin
    for (int b = 0; b < BE_W; b++) begin
      merged[b*BYTE_W +: BYTE_W] = i_fwd_be[b] ? i_fwd_data[b*BYTE_W +: BYTE_W]
                                               : cache_word[b*BYTE_W +: BYTE_W];
    end
  end

  ////////////////////////////////////////////////////
  // merge and writeback registers
  ////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      e3_valid   <= 1'b0;
      o_ld_valid <= 1'b0;
    end else begin
      e3_valid   <= i_e2_valid;
      o_ld_valid <= e3_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    e3_tag         <= i_e2_tag;
    e3_data        <= merged;
    e3_forwarded   <= |i_fwd_be;
    o_ld_tag       <= e3_tag;
    o_ld_data      <= e3_data;
    o_ld_forwarded <= e3_forwarded;
  end

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/100ps

module lsu_top
  import lsu_pkg::*;
#(
  parameter int STQ_DEPTH = 4
) (
  input  logic              i_clk,
  input  logic              i_reset,

  input  logic              i_disp_valid,
  input  logic              i_disp_is_store,
  input  mem_op_u           i_disp_op,
  output logic              o_disp_ready,

  input  logic              i_commit,

  output logic              o_ld_valid,
  output logic [TAG_W-1:0]  o_ld_tag,
  output logic [DATA_W-1:0] o_ld_data,
  output logic              o_ld_forwarded
);

  logic              ld_disp_valid;
  logic              st_disp_valid;

  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;
  logic              rd_written;

  logic              search_valid;
  logic [ADDR_W-1:0] search_addr;
  logic [DATA_W-1:0] fwd_data;
  logic [BE_W-1:0]   fwd_be;

  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [BE_W-1:0]   wr_be;

  logic              e2_valid;
  logic [TAG_W-1:0]  e2_tag;

  // one operation per cycle, steered by its kind.
  assign ld_disp_valid = i_disp_valid & ~i_disp_is_store;
  assign st_disp_valid = i_disp_valid & i_disp_is_store;

  ////////////////////////////////////////////////////
  // load pipe and store queue
  ////////////////////////////////////////////////////

  lsu_load_pipe u_load_pipe (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_ld_valid     (ld_disp_valid),
    .i_ld_op        (i_disp_op),
    .o_rd_addr      (rd_addr),
    .o_search_valid (search_valid),
    .o_search_addr  (search_addr),
    .o_e2_valid     (e2_valid),
    .o_e2_tag       (e2_tag)
  );

  lsu_stq #(
    .STQ_DEPTH (STQ_DEPTH)
  ) u_stq (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_st_valid     (st_disp_valid),
    .i_st_op        (i_disp_op),
    .o_ready        (o_disp_ready),
    .i_commit       (i_commit),
    .o_wr_en        (wr_en),
    .o_wr_addr      (wr_addr),
    .o_wr_data      (wr_data),
    .o_wr_be        (wr_be),
    .i_search_valid (search_valid),
    .i_search_addr  (search_addr),
    .o_fwd_data     (fwd_data),
    .o_fwd_be       (fwd_be)
  );

  ////////////////////////////////////////////////////
  // cache and writeback
  ////////////////////////////////////////////////////

  lsu_dcache u_dcache (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_rd_addr    (rd_addr),
    .i_wr_en      (wr_en),
    .i_wr_addr    (wr_addr),
    .i_wr_data    (wr_data),
    .i_wr_be      (wr_be),
    .o_rd_data    (rd_data),
    .o_rd_written (rd_written)
  );

  lsu_fwd_merge u_fwd_merge (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_e2_valid     (e2_valid),
    .i_e2_tag       (e2_tag),
    .i_rd_data      (rd_data),
    .i_rd_written   (rd_written),
    .i_fwd_data     (fwd_data),
    .i_fwd_be       (fwd_be),
    .o_ld_valid     (o_ld_valid),
    .o_ld_tag       (o_ld_tag),
    .o_ld_data      (o_ld_data),
    .o_ld_forwarded (o_ld_forwarded)
  );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
  parameter int HALF_PERIOD = 4
) (
  output logic o_clk
);

  // 8 ns period.
  initial begin
    o_clk = 1'b0;
    forever begin
      #(HALF_PERIOD) o_clk = ~o_clk;
    end
  end

endmodule

//--- tests/lsu_assertions.sv
`timescale 1ns/100ps

module lsu_assertions #(
  parameter int STQ_DEPTH = 4
) (
  input logic                       i_clk,
  input logic                       i_reset,
  input logic                       i_st_valid,
  input logic                       i_commit,
  input logic                       i_ready,
  input logic [$clog2(STQ_DEPTH):0] i_count
);

  localparam int CNT_W = $clog2(STQ_DEPTH) + 1;
  localparam logic [CNT_W-1:0] FULL = CNT_W'(STQ_DEPTH);

  logic [CNT_W-1:0] occupancy;

  // fill level rebuilt from the accepted stores and the commits.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      occupancy <= '0;
    end else begin
      occupancy <= occupancy + CNT_W'(i_st_valid && i_ready)
                             - CNT_W'(i_commit && (occupancy != '0));
    end
  end

  commit_not_empty: assert property (
    @(posedge i_clk) disable iff (i_reset) i_commit |-> (i_count != '0)
  ) else $error("commit issued while the store queue is empty");

  no_push_when_full: assert property (
    @(posedge i_clk) disable iff (i_reset) (i_st_valid && i_ready) |-> (occupancy < FULL)
  ) else $error("store accepted while the store queue is full");

  ready_tracks_count: assert property (
    @(posedge i_clk) disable iff (i_reset)
      (i_ready == (occupancy < FULL)) && (i_count == occupancy)
  ) else $error("store queue ready does not match its fill level");

endmodule

//--- tests/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb
  import lsu_pkg::*;
();

  localparam int STQ_DEPTH = 4;
  localparam int LD_LATENCY = 3;
  localparam int MAX_RECORDS = 64;
  localparam int REC_WORDS = 8;
  localparam logic [31:0] LFSR_SEED = 32'hb0500de9;

  // record kinds in the stimulus file.
  localparam logic [31:0] K_IDLE = 32'h0;
  localparam logic [31:0] K_LOAD = 32'h1;
  localparam logic [31:0] K_STORE = 32'h2;
  localparam logic [31:0] K_COMMIT = 32'h3;
  localparam logic [31:0] K_END = 32'hf;

  logic              clk;
  logic              reset;
  logic              disp_valid;
  logic              disp_is_store;
  mem_op_u           disp_op;
  logic              disp_ready;
  logic              commit;
  logic              ld_valid;
  logic [TAG_W-1:0]  ld_tag;
  logic [DATA_W-1:0] ld_data;
  logic              ld_forwarded;

  logic [31:0] stim [MAX_RECORDS*REC_WORDS];
  logic [31:0] lfsr_state;
  int          cycle = 0;
  int          timeout_limit = 0;
  int          num_records;
  int          checks = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  // loads in flight, oldest first.
  logic [TAG_W-1:0]  exp_tag_q [$];
  logic [DATA_W-1:0] exp_data_q [$];
  logic              exp_fwd_q [$];
  int                accept_q [$];

  tb_clock u_clock (
    .o_clk (clk)
  );

  lsu_top #(
    .STQ_DEPTH (STQ_DEPTH)
  ) dut (
    .i_clk          (clk),
    .i_reset        (reset),
    .i_disp_valid   (disp_valid),
    .i_disp_is_store(disp_is_store),
    .i_disp_op      (disp_op),
    .o_disp_ready   (disp_ready),
    .i_commit       (commit),
    .o_ld_valid     (ld_valid),
    .o_ld_tag       (ld_tag),
    .o_ld_data      (ld_data),
    .o_ld_forwarded (ld_forwarded)
  );

  bind lsu_stq lsu_assertions #(
    .STQ_DEPTH (STQ_DEPTH)
  ) u_assertions (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_st_valid (i_st_valid),
    .i_commit   (i_commit),
    .i_ready    (o_ready),
    .i_count    (count)
  );

  ////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////

  // galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    test_errors++;
    $display("%s", what);
  endtask

  task automatic idle_gap();
    logic [1:0] gap;
    gap[0] = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
    gap[1] = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
    repeat (gap) @(negedge clk);
  endtask

  task automatic drive_record(input int r);
    int          base;
    logic [31:0] kind;
    base = r * REC_WORDS;
    kind = stim[base+1];
    case (kind)
      K_IDLE: @(negedge clk);
      K_LOAD: begin
        disp_op = '0;
        disp_op.ld.addr = stim[base+2][ADDR_W-1:0];
        disp_op.ld.tag = stim[base+5][TAG_W-1:0];
        disp_is_store = 1'b0;
        disp_valid = 1'b1;
        exp_tag_q.push_back(stim[base+5][TAG_W-1:0]);
        exp_data_q.push_back(stim[base+6]);
        exp_fwd_q.push_back(stim[base+7][0]);
        accept_q.push_back(cycle + 1);
        @(negedge clk);
        disp_valid = 1'b0;
      end
      K_STORE: begin
        while (!disp_ready) @(negedge clk);
        disp_op = '0;
        disp_op.st.addr = stim[base+2][ADDR_W-1:0];
        disp_op.st.data = stim[base+3];
        disp_op.st.be = stim[base+4][BE_W-1:0];
        disp_is_store = 1'b1;
        disp_valid = 1'b1;
        @(negedge clk);
        disp_valid = 1'b0;
        disp_is_store = 1'b0;
      end
      K_COMMIT: begin
        check_value("o_disp_ready", 32'(disp_ready), stim[base+7]);
        commit = 1'b1;
        @(negedge clk);
        commit = 1'b0;
      end
      default: note_failure($sformatf("record %0d has an unknown kind %h", r, kind));
    endcase
  endtask

  // waits for the test's last load to come back before reporting it.
  task automatic finish_test(input int t);
    while (exp_data_q.size() != 0) @(negedge clk);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d: ok", t);
    end else begin
      tests_failed++;
      $display("test %0d: %0d errors", t, test_errors);
    end
    test_errors = 0;
  endtask

  ////////////////////////////////////////////////////
  // cycle count, timeout and writeback monitor
  ////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  initial begin
    wait (timeout_limit > 0);
    while (cycle < timeout_limit) @(posedge clk);
    $display("timeout: the run did not end within %0d cycles", timeout_limit);
    $display("test failed");
    $finish;
  end

  always @(negedge clk) begin
    if (!reset && ld_valid) begin
      if (exp_data_q.size() == 0) begin
        note_failure("a load writeback arrived with no load outstanding");
      end else begin
        check_value("o_ld_tag", 32'(ld_tag), 32'(exp_tag_q.pop_front()));
        check_value("o_ld_data", ld_data, exp_data_q.pop_front());
        check_value("o_ld_forwarded", 32'(ld_forwarded), 32'(exp_fwd_q.pop_front()));
        check_value("load latency", 32'(cycle - accept_q.pop_front()), 32'(LD_LATENCY));
      end
    end
  end

  ////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////

  initial begin
    int cur_test;
    int r;
    reset = 1'b1;
    disp_valid = 1'b0;
    disp_is_store = 1'b0;
    disp_op = '0;
    commit = 1'b0;
    lfsr_state = LFSR_SEED;

    $readmemh("tests/lsu_stimulus.txt", stim);
    num_records = 0;
    while (num_records < MAX_RECORDS && stim[num_records*REC_WORDS+1] !== K_END) begin
      num_records++;
    end
    if (num_records == MAX_RECORDS) begin
      note_failure("the stimulus file has no end record");
      num_records = 0;
    end
    timeout_limit = num_records * 7 + 200;

    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    cur_test = int'(stim[0]);
    check_value("o_ld_valid", 32'(ld_valid), 32'd0);
    check_value("o_disp_ready", 32'(disp_ready), 32'd1);

    for (r = 0; r < num_records; r++) begin
      if (int'(stim[r*REC_WORDS]) != cur_test) begin
        finish_test(cur_test);
        cur_test = int'(stim[r*REC_WORDS]);
      end
      // back-to-back loads and the store right behind a load need no gaps.
      if (cur_test < 5) begin
        idle_gap();
      end
      drive_record(r);
    end
    if (num_records > 0) begin
      finish_test(cur_test);
    end

    $display("%0d tests, %0d failed, %0d checks, %0d errors, store queue depth %0d",
             tests_run, tests_failed, checks, errors, STQ_DEPTH);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- tests/lsu_stimulus.txt
// test kind addr data be tag expdata expflag. kind 0 idle, 1 load, 2 store, 3 commit, f end.
// expflag is the forwarded flag of a load and the o_disp_ready level seen before a commit.
// test 1: never written words read as zero
1 1 01 00000000 0 01 00000000 0
1 0 00 00000000 0 00 00000000 0
1 1 2a 00000000 0 02 00000000 0
1 1 3f 00000000 0 03 00000000 0
// test 2: committed stores with byte enables
2 2 05 11223344 f 00 00000000 0
2 3 00 00000000 0 00 00000000 1
2 1 05 00000000 0 04 11223344 0
2 2 05 aabbccdd 5 00 00000000 0
2 3 00 00000000 0 00 00000000 1
2 1 05 00000000 0 05 11bb33dd 0
// test 3: byte forwarding, youngest store wins
3 2 10 01020304 f 00 00000000 0
3 3 00 00000000 0 00 00000000 1
3 2 10 a0a1a2a3 3 00 00000000 0
3 2 11 eeeeeeee f 00 00000000 0
3 2 10 b0b1b2b3 2 00 00000000 0
3 1 10 00000000 0 06 0102b2a3 1
3 1 11 00000000 0 07 eeeeeeee 1
3 3 00 00000000 0 00 00000000 1
3 3 00 00000000 0 00 00000000 1
3 3 00 00000000 0 00 00000000 1
3 1 10 00000000 0 08 0102b2a3 0
// test 4: full queue drops ready until a commit
4 2 20 c0000020 f 00 00000000 0
4 2 21 c0000021 f 00 00000000 0
4 2 22 c0000022 f 00 00000000 0
4 2 23 c0000023 f 00 00000000 0
4 3 00 00000000 0 00 00000000 0
4 2 24 d0000024 f 00 00000000 0
4 1 20 00000000 0 09 c0000020 0
4 1 23 00000000 0 0a c0000023 1
4 1 24 00000000 0 0b d0000024 1
4 3 00 00000000 0 00 00000000 0
4 3 00 00000000 0 00 00000000 1
4 3 00 00000000 0 00 00000000 1
4 3 00 00000000 0 00 00000000 1
4 1 24 00000000 0 0c d0000024 0
// test 5: back-to-back loads
5 1 05 00000000 0 0d 11bb33dd 0
5 1 10 00000000 0 0e 0102b2a3 0
5 1 20 00000000 0 0f c0000020 0
5 1 01 00000000 0 10 00000000 0
5 1 24 00000000 0 11 d0000024 0
// test 6: store after a load, commit on the search edge
6 1 30 00000000 0 12 00000000 0
6 2 30 99999999 f 00 00000000 0
6 1 30 00000000 0 13 99999999 1
6 3 00 00000000 0 00 00000000 1
6 1 30 00000000 0 14 99999999 0
0 f 00 00000000 0 00 00000000 0

//--- verilog.f
hw/lsu_pkg.sv
hw/lsu_dcache.sv
hw/lsu_load_pipe.sv
hw/lsu_stq.sv
hw/lsu_fwd_merge.sv
hw/lsu_top.sv
tests/tb_clock.sv
tests/lsu_assertions.sv
tests/lsu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the LSU testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Wno-fatal \
  --top-module lsu_tb -f verilog.f -Mdir obj_dir -o lsu_sim > build.log 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
